// File: Makefile
# Verilator build and run of the fetch front end testbench

SIM      := verilator
FLAGS    := --binary -Wno-fatal -j 0
TOP      := fetch_tb
FILELIST := sources.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run exits non-zero when the testbench stops with a failure
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: source/bus_cen.sv
// bus_cen: clock-enable generator pacing bus cycles and window updates
`timescale 1ns/1ps
`default_nettype none

module bus_cen
    import mem_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    output logic      cen
);

    // position inside the current bus period
    logic [CEN_CNT_W-1:0] cnt;

    // cen is registered so it is clean of counter glitches
    // first pulse lands BUS_RATIO clocks after reset release
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            cen <= 1'b0;
        end else begin
            if (cnt == CEN_CNT_W'(CEN_LAST)) begin
                // wrap and mark the bus cycle
                cnt <= '0;
                cen <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
                cen <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
// fetch_pkg: byte address, four-byte window and byte mask types with their constants
`default_nettype none

package fetch_pkg;

    // byte address width of the core bus
    localparam int ADDR_W = 24;

    // one window byte
    localparam int BYTE_W = 8;

    // the window always holds four consecutive bytes
    localparam int WINDOW_BYTES = 4;
    localparam int WINDOW_W = WINDOW_BYTES * BYTE_W;

    // byte address, no alignment implied
    typedef logic [ADDR_W-1:0] addr_t;

    // single byte, used for the load port and window lanes
    typedef logic [BYTE_W-1:0] byte_t;

    // little endian window
    // bits 7:0 hold the byte at the window base
    typedef logic [WINDOW_W-1:0] window_t;

    // one bit per window byte
    // used for both the valid set and the still-to-fetch set
    typedef logic [WINDOW_BYTES-1:0] byte_mask_t;

    // empty and full masks
    localparam byte_mask_t MASK_NONE = '0;
    localparam byte_mask_t MASK_ALL = '1;

endpackage

`default_nettype wire

// File: source/fetch_top.sv
// fetch_top: fetch front end with bus clock enable, word RAM and window controller
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
    import mem_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,

    // request inputs
    input  wire addr_t pc,
    input  wire addr_t idx_addr,
    input  wire logic  ldram_en,

    // external RAM load port
    input  wire logic  load_we,
    input  wire addr_t load_addr,
    input  wire byte_t load_data,

    // window out, valid while ram_rdy is high
    output window_t    dout,
    output logic       ram_rdy
);

    // bus pacing
    logic cen;

    // word bus between the window controller and the RAM
    addr_t ram_addr;
    word_t ram_dout;

    // one pulse per bus period
    bus_cen u_bus_cen (
        .clk (clk),
        .rst (rst),
        .cen (cen)
    );

    // zero wait state word memory
    word_ram u_word_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_dout  (ram_dout),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // four-byte window over the word bus
    fetch_window u_fetch_window (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .idx_addr (idx_addr),
        .pc       (pc),
        .ram_addr (ram_addr),
        .ram_dout (ram_dout),
        .dout     (dout),
        .ram_rdy  (ram_rdy)
    );

endmodule

`default_nettype wire

// File: source/fetch_window.sv
// fetch_window: four-byte fetch window controller with partial-reuse refill
`timescale 1ns/1ps
`default_nettype none

module fetch_window
    import fetch_pkg::*;
    import mem_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  cen,

    // request sources
    input  wire logic  ldram_en,
    input  wire addr_t idx_addr,
    input  wire addr_t pc,

    // word bus towards the RAM
    output addr_t      ram_addr,
    input  wire word_t ram_dout,

    // window out
    output window_t    dout,
    output logic       ram_rdy
);

    // current request, data load address wins when selected
    addr_t req;

    // address of window byte 0
    addr_t base;

    // distance from the window base to the request
    addr_t delta;

    // window contents, byte i at base + i
    window_t win;

    // bytes that hold good data
    byte_mask_t vld;

    // bytes still waiting for a bus word
    byte_mask_t fetch;

    // per byte, stored this bus cycle and which lane it comes from
    byte_mask_t take;
    byte_mask_t lane_hi;

    // request lies 1 to 3 bytes past a full window
    logic reuse;

    // bytes dropped from the low end, 0 means full refill
    logic [1:0] shift;

    // bus cycle actions
    logic fill_go;
    logic start_go;

    assign req = ldram_en ? idx_addr : pc;
    assign delta = req - base;

    // ready only for a full window sitting at the request
    // a request change drops this in the same cycle
    assign ram_rdy = (vld == MASK_ALL) && (delta == '0);

    // reuse needs every byte valid, otherwise the shifted data is junk
    assign reuse = (vld == MASK_ALL) && (delta[ADDR_W-1:2] == '0) && (delta[1:0] != 2'd0);
    assign shift = reuse ? delta[1:0] : 2'd0;

    // pending bytes are served first, new requests wait until idle
    assign fill_go = cen && (fetch != MASK_NONE);
    assign start_go = cen && (fetch == MASK_NONE) && !ram_rdy;

    // map the bus word onto the pending window bytes
    // a byte is taken when its word matches the bus address word
    for (genvar i = 0; i < WINDOW_BYTES; i++) begin : g_lane
        addr_t byte_addr;

        assign byte_addr = base + addr_t'(i);
        assign take[i] = fetch[i] && (byte_addr[ADDR_W-1:1] == ram_addr[ADDR_W-1:1]);
        // odd byte addresses sit in the high lane
        assign lane_hi[i] = byte_addr[0];
    end

    // control state, base, masks and bus address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base <= '0;
            vld <= MASK_NONE;
            fetch <= MASK_NONE;
            ram_addr <= '0;
        end else if (fill_go) begin
            // one word per bus cycle, one or two bytes land
            vld <= vld | take;
            fetch <= fetch & ~take;
            // step to the next word, aligned
            ram_addr <= {ram_addr[ADDR_W-1:1] + 1'b1, 1'b0};
        end else if (start_go) begin
            base <= req;
            case (shift)
                2'd1: begin
                    // keep three bytes, read the top one
                    vld <= 4'b0111;
                    fetch <= 4'b1000;
                    ram_addr <= req + addr_t'(3);
                end
                2'd2: begin
                    // keep two bytes, read the upper pair
                    vld <= 4'b0011;
                    fetch <= 4'b1100;
                    ram_addr <= req + addr_t'(2);
                end
                2'd3: begin
                    // only the old top byte survives
                    vld <= 4'b0001;
                    fetch <= 4'b1110;
                    ram_addr <= req + addr_t'(1);
                end
                default: begin
                    // jump, backward step or cold start
                    vld <= MASK_NONE;
                    fetch <= MASK_ALL;
                    ram_addr <= req;
                end
            endcase
        end
    end

    // window bytes, payload only
    always_ff @(posedge clk) begin
        if (fill_go) begin
            for (int i = 0; i < WINDOW_BYTES; i++) begin
                if (take[i]) begin
                    win[i*BYTE_W +: BYTE_W] <= lane_hi[i] ? ram_dout[BYTE_W +: BYTE_W]
                                                          : ram_dout[0 +: BYTE_W];
                end
            end
        end else if (start_go) begin
            // slide kept bytes down to the new base
            case (shift)
                2'd1: win <= win >> BYTE_W;
                2'd2: win <= win >> (2 * BYTE_W);
                2'd3: win <= win >> (3 * BYTE_W);
                default: win <= win;
            endcase
        end
    end

    assign dout = win;

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
// mem_pkg: bus word type, RAM geometry and bus clock ratio constants
`default_nettype none

package mem_pkg;

    // 16-bit data bus, even byte in the low half
    localparam int WORD_W = 16;
    typedef logic [WORD_W-1:0] word_t;

    // word RAM depth and its word address width
    // upper byte address bits are not decoded and alias
    localparam int RAM_WORDS = 4096;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // one bus cycle every BUS_RATIO clocks, 1 or more
    localparam int BUS_RATIO = 2;

    // counter width for the clock enable
    // a ratio of 1 still needs a one-bit counter
    localparam int CEN_CNT_W = (BUS_RATIO > 1) ? $clog2(BUS_RATIO) : 1;

    // last count of a bus period, cen fires here
    localparam int CEN_LAST = BUS_RATIO - 1;

endpackage

`default_nettype wire

// File: source/word_ram.sv
// word_ram: single-port 16-bit word RAM, combinational read, byte-lane load port
`timescale 1ns/1ps
`default_nettype none

module word_ram
    import fetch_pkg::*;
    import mem_pkg::*;
(
    input  wire logic  clk,

    // fetch side, byte address with bit 0 ignored
    input  wire addr_t ram_addr,
    output word_t      ram_dout,

    // byte-wide load port
    input  wire logic  load_we,
    input  wire addr_t load_addr,
    input  wire byte_t load_data
);

    // separate arrays per byte lane
    // low lane holds even bytes, high lane odd bytes
    byte_t mem_lo [RAM_WORDS];
    byte_t mem_hi [RAM_WORDS];

    // word indices, only the low address bits are decoded
    logic [RAM_AW-1:0] rd_idx;
    logic [RAM_AW-1:0] wr_idx;

    assign rd_idx = ram_addr[RAM_AW:1];
    assign wr_idx = load_addr[RAM_AW:1];

    // zero wait state read
    assign ram_dout = {mem_hi[rd_idx], mem_lo[rd_idx]};

    // load writes a single lane picked by address parity
    always_ff @(posedge clk) begin
        if (load_we && !load_addr[0]) begin
            mem_lo[wr_idx] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (load_we && load_addr[0]) begin
            mem_hi[wr_idx] <= load_data;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
source/fetch_pkg.sv
source/mem_pkg.sv
source/bus_cen.sv
source/word_ram.sv
source/fetch_window.sv
source/fetch_top.sv
testbench/fetch_tb.sv

// File: testbench/fetch_golden.txt
# L byte_addr data
# R ldram_en idx_addr pc then expected bytes at request, request+1, request+2, request+3
L 000100 a0
L 000101 a1
L 000102 a2
L 000103 a3
L 000104 a4
L 000105 a5
L 000106 a6
L 000107 a7
L 000108 a8
L 000109 a9
L 00010a aa
L 00010b ab
L 00010c ac
L 00010d ad
L 00010e ae
L 00010f af
L 000110 b0
L 000111 b1
L 000112 b2
L 000113 b3
L 000114 b4
L 000115 b5
L 000116 b6
L 000117 b7
L 000118 b8
L 000119 b9
L 00011a ba
L 00011b bb
L 00011c bc
L 000800 d0
L 000801 d1
L 000802 d2
L 000803 d3
L 000804 d4
L 000805 d5
L 000806 d6
L 000807 d7
L 000808 d8

R 0 000000 000100 a0 a1 a2 a3
R 0 000000 000101 a1 a2 a3 a4
R 0 000000 000103 a3 a4 a5 a6
R 0 000000 000106 a6 a7 a8 a9
R 0 000000 000111 b1 b2 b3 b4
R 0 000000 00010f af b0 b1 b2
R 0 000000 000112 b2 b3 b4 b5
R 0 000000 000113 b3 b4 b5 b6
R 1 000800 000113 d0 d1 d2 d3
R 1 000801 000200 d1 d2 d3 d4
R 1 000803 000100 d3 d4 d5 d6
R 0 000803 000117 b7 b8 b9 ba
R 0 000803 000119 b9 ba bb bc
R 1 000805 000119 d5 d6 d7 d8
R 0 000805 000119 b9 ba bb bc
R 0 000805 012101 a1 a2 a3 a4
R 0 000805 00010a aa ab ac ad

// File: testbench/fetch_tb.sv
// fetch_tb: golden-file testbench for the fetch front end with random request gaps
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
    import mem_pkg::*;
();

    // longest wait for ready after a new request, in clocks
    localparam int MAX_WAIT = 5 * BUS_RATIO;

    // dut inputs
    logic    clk;
    logic    rst;
    addr_t   pc;
    addr_t   idx_addr;
    logic    ldram_en;
    logic    load_we;
    addr_t   load_addr;
    byte_t   load_data;

    // dut outputs
    window_t dout;
    logic    ram_rdy;

    // load records from the golden file
    addr_t   ld_addr_q[$];
    byte_t   ld_data_q[$];

    // request records and their expected windows
    logic    rq_sel_q[$];
    addr_t   rq_idx_q[$];
    addr_t   rq_pc_q[$];
    window_t rq_exp_q[$];

    // goes high once the golden file is in the queues
    logic    parsed;

    // xorshift state for the idle gaps
    logic [31:0] rng;

    fetch_top uut (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .idx_addr  (idx_addr),
        .ldram_en  (ldram_en),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .dout      (dout),
        .ram_rdy   (ram_rdy)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // one xorshift32 step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    // window compare, expected bytes come straight from the golden file
    task automatic check_window(input window_t expected, input window_t actual, input addr_t req);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t: window at %h expected %h, got %h",
                                $time, req, expected, actual));
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual, input string when);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t: ram_rdy %s expected %b, got %b",
                                $time, when, expected, actual));
        end
    endtask

    // parse load and request records, '#' lines are comments
    task automatic read_golden();
        int fd;
        int code;
        logic done;
        logic [63:0] tag;
        logic [8*256-1:0] rest;
        logic [31:0] la, ld;
        logic [31:0] sel, ia, pa;
        logic [31:0] b0, b1, b2, b3;
        fd = $fopen("testbench/fetch_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file testbench/fetch_golden.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "L") begin
                code = $fscanf(fd, " %h %h", la, ld);
                if (code != 2) begin
                    abort_run("malformed load record in the golden file");
                end
                if (rq_sel_q.size() != 0) begin
                    abort_run("load record after a request record in the golden file");
                end
                ld_addr_q.push_back(la[ADDR_W-1:0]);
                ld_data_q.push_back(ld[BYTE_W-1:0]);
            end else if (tag == "R") begin
                code = $fscanf(fd, " %h %h %h %h %h %h %h", sel, ia, pa, b0, b1, b2, b3);
                if (code != 7) begin
                    abort_run("malformed request record in the golden file");
                end
                rq_sel_q.push_back(sel[0]);
                rq_idx_q.push_back(ia[ADDR_W-1:0]);
                rq_pc_q.push_back(pa[ADDR_W-1:0]);
                // byte at the request goes to the low end
                rq_exp_q.push_back({b3[7:0], b2[7:0], b1[7:0], b0[7:0]});
            end else begin
                abort_run("unknown record type in the golden file");
            end
        end
        $fclose(fd);
    endtask

    // watchdog sized from the record counts
    initial begin
        int limit_ns;
        wait (parsed === 1'b1);
        limit_ns = (rq_sel_q.size() * (5 * BUS_RATIO + 4) + ld_addr_q.size() + 20) * 10;
        #(limit_ns);
        abort_run($sformatf("watchdog expired after %0d ns, the run did not finish", limit_ns));
    end

    initial begin
        int gap;
        int waited;
        addr_t req;
        addr_t prev_req;
        clk = 1'b0;
        rst = 1'b1;
        pc = '0;
        idx_addr = '0;
        ldram_en = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        parsed = 1'b0;
        rng = 32'd49;

        read_golden();
        parsed = 1'b1;

        // two clocks of reset, release on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_ready(1'b0, ram_rdy, "during reset");
        rst = 1'b0;
        @(negedge clk);
        check_ready(1'b0, ram_rdy, "one clock after reset release");

        // preload the RAM one byte per clock
        foreach (ld_addr_q[i]) begin
            @(negedge clk);
            load_we = 1'b1;
            load_addr = ld_addr_q[i];
            load_data = ld_data_q[i];
        end
        @(negedge clk);
        load_we = 1'b0;

        // effective request after reset is pc
        prev_req = pc;
        for (int n = 0; n < rq_sel_q.size(); n++) begin
            // idle clocks with the old request held
            // ready and the served window must stay put
            rng = xorshift32(rng);
            gap = int'(rng[1:0]);
            repeat (gap) begin
                @(negedge clk);
                if (n > 0) begin
                    check_ready(1'b1, ram_rdy, "with the request held");
                    check_window(rq_exp_q[n-1], dout, prev_req);
                end
            end

            ldram_en = rq_sel_q[n];
            idx_addr = rq_idx_q[n];
            pc = rq_pc_q[n];
            req = rq_sel_q[n] ? rq_idx_q[n] : rq_pc_q[n];

            // a new address drops ready in the same cycle
            #1;
            if (req != prev_req) begin
                check_ready(1'b0, ram_rdy, "right after a request change");
            end

            waited = 0;
            @(negedge clk);
            while (ram_rdy !== 1'b1) begin
                if (waited >= MAX_WAIT) begin
                    abort_run($sformatf("ram_rdy did not rise within %0d clocks for request %h",
                                        MAX_WAIT, req));
                end
                @(negedge clk);
                waited++;
            end
            check_window(rq_exp_q[n], dout, req);
            prev_req = req;
        end

        if (rq_sel_q.size() == 0) begin
            abort_run("the golden file holds no request records");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
